//--- dv/gl_clock_gen.sv
`timescale 1ns/1ps

module gl_clock_gen #(
    parameter int PERIOD       = 4,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset drops on a rising edge
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- dv/gl_command_core_tb.sv
`timescale 1ns/1ps

`include "gl_settings.svh"

module gl_command_core_tb
    import gl_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int MEM_WORDS    = 1 << `GL_ADDR_W;
    localparam int NUM_CMDS     = 24;

    // Strobe kinds in the event lists
    localparam int EV_PUSH    = 1;
    localparam int EV_POP     = 2;
    localparam int EV_LOAD    = 3;
    localparam int EV_LOAD_ID = 4;
    localparam int EV_MUL     = 5;
    localparam int EV_PERSP   = 6;

    // Same bit order as a command word
    typedef struct packed {
        logic                 is_ref;
        logic [`GL_IMM_W-1:0] imm;
        gl_opcode_e           op;
    } cmd_t;

    //////////////////////////////
    // Command table
    //////////////////////////////
    localparam cmd_t CMD_TABLE [NUM_CMDS] = '{
        '{1'b0, 23'h000000, OP_POP_COLOR},
        '{1'b0, 23'h012345, OP_COLOR},
        '{1'b1, 23'h000100, OP_VIEWPORT},
        '{1'b1, 23'h000110, OP_COLOR},
        '{1'b0, 23'h000000, OP_PUSH_COLOR},
        '{1'b0, 23'h000abc, OP_COLOR},
        '{1'b0, 23'h000000, OP_POP_COLOR},
        '{1'b0, 23'h000000, OP_PUSH_COLOR},
        '{1'b0, 23'h0b0b0b, OP_COLOR},
        '{1'b0, 23'h000000, OP_PUSH_COLOR},
        '{1'b0, 23'h000000, OP_PUSH_COLOR},
        '{1'b0, 23'h000000, OP_PUSH_COLOR},
        '{1'b0, 23'h000000, OP_PUSH_COLOR},
        '{1'b0, 23'h000000, OP_POP_COLOR},
        '{1'b0, 23'h000001, OP_MATRIX_MODE},
        '{1'b1, 23'h000120, OP_LOAD_MATRIX},
        '{1'b0, 23'h000000, OP_LOAD_IDENTITY},
        '{1'b1, 23'h000131, OP_MULT_MATRIX},
        '{1'b0, 23'h000040, OP_MULT_MATRIX},
        '{1'b0, 23'h000000, OP_PERSP_DIV},
        '{1'b0, 23'h000000, gl_opcode_e'(8'h55)},
        '{1'b0, 23'h000000, OP_HALT},
        // Never reached
        '{1'b0, 23'h0007ff, OP_COLOR},
        '{1'b0, 23'h000000, OP_MATRIX_MODE}
    };

    logic                  clk;
    logic                  rst_n;
    logic [`GL_WORD_W-1:0] inst_data      = '0;
    logic [`GL_WORD_W-1:0] operand_data_0 = '0;
    logic [`GL_WORD_W-1:0] operand_data_1 = '0;
    logic [`GL_WORD_W-1:0] operand_data_2 = '0;
    logic [`GL_WORD_W-1:0] operand_data_3 = '0;
    logic [`GL_ADDR_W-1:0] inst_addr;
    logic [`GL_ADDR_W-1:0] operand_addr;
    logic                  halted;
    logic [`GL_WORD_W-1:0] viewport_min_x;
    logic [`GL_WORD_W-1:0] viewport_min_y;
    logic [`GL_WORD_W-1:0] viewport_max_x;
    logic [`GL_WORD_W-1:0] viewport_max_y;
    logic [`GL_WORD_W-1:0] color_out;
    logic                  push_en;
    logic                  pop_en;
    logic                  matrix_mode_out;
    logic                  matrix_load_en;
    logic                  matrix_load_id_en;
    logic                  matrix_mul_en;
    logic                  matrix_mul_type;
    logic [`GL_ADDR_W-1:0] matrix_addr;
    logic                  perspective_div_en;

    logic [`GL_WORD_W-1:0] mem [MEM_WORDS];
    logic [31:0]           seen_events [$];
    logic [31:0]           exp_events [$];
    logic [`GL_WORD_W-1:0] seen_pop_colors [$];
    logic [`GL_WORD_W-1:0] exp_pop_colors [$];
    logic [`GL_WORD_W-1:0] exp_viewport [4];
    logic [`GL_WORD_W-1:0] exp_color;
    logic                  exp_mode;

    gl_clock_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (RESET_CYCLES)
    ) u_clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    gl_command_core dut (
        .clk                (clk),
        .rst_n              (rst_n),
        .inst_data          (inst_data),
        .operand_data_0     (operand_data_0),
        .operand_data_1     (operand_data_1),
        .operand_data_2     (operand_data_2),
        .operand_data_3     (operand_data_3),
        .inst_addr          (inst_addr),
        .operand_addr       (operand_addr),
        .halted             (halted),
        .viewport_min_x     (viewport_min_x),
        .viewport_min_y     (viewport_min_y),
        .viewport_max_x     (viewport_max_x),
        .viewport_max_y     (viewport_max_y),
        .color_out          (color_out),
        .push_en            (push_en),
        .pop_en             (pop_en),
        .matrix_mode_out    (matrix_mode_out),
        .matrix_load_en     (matrix_load_en),
        .matrix_load_id_en  (matrix_load_id_en),
        .matrix_mul_en      (matrix_mul_en),
        .matrix_mul_type    (matrix_mul_type),
        .matrix_addr        (matrix_addr),
        .perspective_div_en (perspective_div_en)
    );

    function automatic logic [31:0] event_word(input int kind, input logic mul_type,
                                               input logic [`GL_ADDR_W-1:0] addr);
        event_word = {12'h0, kind[3:0], 3'b0, mul_type, 2'b0, addr};
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    // Walk the table with the command rules up to the HALT
    task automatic build_expected();
        logic [`GL_WORD_W-1:0] stack [$];
        logic [`GL_ADDR_W-1:0] a;
        cmd_t                  c;
        for (int k = 0; k < 4; k++)
            exp_viewport[k] = '0;
        exp_color = '0;
        exp_mode  = 1'b0;
        for (int i = 0; i < NUM_CMDS; i++)
        begin
            c = CMD_TABLE[i];
            a = c.imm[`GL_ADDR_W-1:0];
            if (c.op == OP_HALT)
                break;
            case (c.op)
                OP_VIEWPORT:
                    for (int k = 0; k < 4; k++)
                        exp_viewport[k] = mem[(a + k) % MEM_WORDS];
                OP_COLOR:
                    exp_color = c.is_ref ? mem[a] : {9'b0, c.imm};
                OP_PUSH_COLOR:
                    if (stack.size() < `GL_COLOR_STACK_DEPTH)
                    begin
                        stack.push_back(exp_color);
                        exp_events.push_back(event_word(EV_PUSH, 1'b0, '0));
                    end
                OP_POP_COLOR:
                    if (stack.size() > 0)
                    begin
                        exp_color = stack.pop_back();
                        exp_events.push_back(event_word(EV_POP, 1'b0, '0));
                        exp_pop_colors.push_back(exp_color);
                    end
                OP_MATRIX_MODE:   exp_mode = c.imm[0];
                OP_LOAD_MATRIX:   exp_events.push_back(event_word(EV_LOAD, 1'b0, a));
                OP_LOAD_IDENTITY: exp_events.push_back(event_word(EV_LOAD_ID, 1'b0, '0));
                OP_MULT_MATRIX:   exp_events.push_back(event_word(EV_MUL, c.imm[0], a));
                OP_PERSP_DIV:     exp_events.push_back(event_word(EV_PERSP, 1'b0, '0));
                default:
                begin
                end
            endcase
        end
    endtask

    //////////////////////////////
    // Command memory model
    //////////////////////////////
    always @(posedge clk)
    begin
        inst_data      <= mem[inst_addr];
        operand_data_0 <= mem[operand_addr];
        operand_data_1 <= mem[operand_addr + 2'd1];
        operand_data_2 <= mem[operand_addr + 2'd2];
        operand_data_3 <= mem[operand_addr + 2'd3];
    end

    // Strobes sampled mid-cycle
    always @(negedge clk)
    begin
        if (rst_n)
        begin
            if (push_en)
                seen_events.push_back(event_word(EV_PUSH, 1'b0, '0));
            if (pop_en)
            begin
                seen_events.push_back(event_word(EV_POP, 1'b0, '0));
                // Restored colour is visible with the pop strobe
                seen_pop_colors.push_back(color_out);
            end
            if (matrix_load_en)
                seen_events.push_back(event_word(EV_LOAD, 1'b0, matrix_addr));
            if (matrix_load_id_en)
                seen_events.push_back(event_word(EV_LOAD_ID, 1'b0, '0));
            if (matrix_mul_en)
                seen_events.push_back(event_word(EV_MUL, matrix_mul_type, matrix_addr));
            if (perspective_div_en)
                seen_events.push_back(event_word(EV_PERSP, 1'b0, '0));
        end
    end

    initial
    begin
        #((RESET_CYCLES + 2 * NUM_CMDS + 40) * CLK_PERIOD);
        $display("Timeout while waiting for the command stream to halt");
        $display("Checks failed");
        $fatal(1, "Watchdog expired");
    end

    //////////////////////////////
    // Main sequence
    //////////////////////////////
    initial
    begin
        void'($urandom(5));
        for (int a = 0; a < MEM_WORDS; a++)
            mem[a] = 32'hc0de_0000 ^ a;
        for (int i = 0; i < NUM_CMDS; i++)
        begin
            mem[i] = CMD_TABLE[i];
            // Random operand words behind each address immediate
            if (CMD_TABLE[i].is_ref)
                for (int k = 0; k < 4; k++)
                    mem[(CMD_TABLE[i].imm[`GL_ADDR_W-1:0] + k) % MEM_WORDS] = $urandom();
        end
        build_expected();

        @(posedge rst_n);
        @(negedge clk);
        compare_value("reset strobes", '0, {push_en, pop_en, matrix_load_en,
                      matrix_load_id_en, matrix_mul_en, perspective_div_en});
        compare_value("reset halted", '0, halted);
        compare_value("reset viewport_min_x", '0, viewport_min_x);
        compare_value("reset viewport_min_y", '0, viewport_min_y);
        compare_value("reset viewport_max_x", '0, viewport_max_x);
        compare_value("reset viewport_max_y", '0, viewport_max_y);
        compare_value("reset color", '0, color_out);
        compare_value("reset matrix mode", '0, matrix_mode_out);

        wait (halted === 1'b1);
        // Halt must hold and later commands stay out
        repeat (8)
        begin
            @(negedge clk);
            compare_value("halted held", 1, halted);
        end

        compare_value("viewport_min_x", exp_viewport[0], viewport_min_x);
        compare_value("viewport_min_y", exp_viewport[1], viewport_min_y);
        compare_value("viewport_max_x", exp_viewport[2], viewport_max_x);
        compare_value("viewport_max_y", exp_viewport[3], viewport_max_y);
        compare_value("final color", exp_color, color_out);
        compare_value("matrix mode", exp_mode, matrix_mode_out);
        compare_value("strobe event count", exp_events.size(), seen_events.size());
        for (int i = 0; i < exp_events.size(); i++)
            compare_value($sformatf("strobe event %0d", i), exp_events[i], seen_events[i]);
        compare_value("pop color count", exp_pop_colors.size(), seen_pop_colors.size());
        for (int i = 0; i < exp_pop_colors.size(); i++)
            compare_value($sformatf("pop color %0d", i), exp_pop_colors[i],
                          seen_pop_colors[i]);

        $display("All checks passed");
        $finish;
    end

endmodule

//--- run.sh
#!/bin/sh
# Build and run the command core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f vlog.f \
    --top-module gl_command_core_tb \
    -o gl_command_core_tb

./obj_dir/gl_command_core_tb

//--- source/gl_command_core.sv
`timescale 1ns/1ps

`include "gl_settings.svh"

module gl_command_core
    import gl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`GL_WORD_W-1:0] inst_data,
    input  logic [`GL_WORD_W-1:0] operand_data_0,
    input  logic [`GL_WORD_W-1:0] operand_data_1,
    input  logic [`GL_WORD_W-1:0] operand_data_2,
    input  logic [`GL_WORD_W-1:0] operand_data_3,
    output logic [`GL_ADDR_W-1:0] inst_addr,
    output logic [`GL_ADDR_W-1:0] operand_addr,
    output logic                  halted,
    output logic [`GL_WORD_W-1:0] viewport_min_x,
    output logic [`GL_WORD_W-1:0] viewport_min_y,
    output logic [`GL_WORD_W-1:0] viewport_max_x,
    output logic [`GL_WORD_W-1:0] viewport_max_y,
    output logic [`GL_WORD_W-1:0] color_out,
    output logic                  push_en,
    output logic                  pop_en,
    output logic                  matrix_mode_out,
    output logic                  matrix_load_en,
    output logic                  matrix_load_id_en,
    output logic                  matrix_mul_en,
    output logic                  matrix_mul_type,
    output logic [`GL_ADDR_W-1:0] matrix_addr,
    output logic                  perspective_div_en
);

    // Fetch to decode
    logic                  stall;
    logic [`GL_WORD_W-1:0] inst;
    logic                  inst_valid;

    // Decode to state unit
    logic                  issue;
    gl_opcode_e            op;
    logic [`GL_IMM_W-1:0]  literal;
    logic [`GL_WORD_W-1:0] operand_0;
    logic [`GL_WORD_W-1:0] operand_1;
    logic [`GL_WORD_W-1:0] operand_2;
    logic [`GL_WORD_W-1:0] operand_3;

    gl_fetch u_fetch (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .inst_data  (inst_data),
        .inst_addr  (inst_addr),
        .inst       (inst),
        .inst_valid (inst_valid)
    );

    gl_decode u_decode (
        .clk            (clk),
        .rst_n          (rst_n),
        .inst           (inst),
        .inst_valid     (inst_valid),
        .operand_data_0 (operand_data_0),
        .operand_data_1 (operand_data_1),
        .operand_data_2 (operand_data_2),
        .operand_data_3 (operand_data_3),
        .stall          (stall),
        .halted         (halted),
        .operand_addr   (operand_addr),
        .issue          (issue),
        .op             (op),
        .literal        (literal),
        .operand_0      (operand_0),
        .operand_1      (operand_1),
        .operand_2      (operand_2),
        .operand_3      (operand_3)
    );

    gl_state_unit u_state_unit (
        .clk                (clk),
        .rst_n              (rst_n),
        .issue              (issue),
        .op                 (op),
        .literal            (literal),
        .operand_0          (operand_0),
        .operand_1          (operand_1),
        .operand_2          (operand_2),
        .operand_3          (operand_3),
        .operand_addr       (operand_addr),
        .viewport_min_x     (viewport_min_x),
        .viewport_min_y     (viewport_min_y),
        .viewport_max_x     (viewport_max_x),
        .viewport_max_y     (viewport_max_y),
        .color_out          (color_out),
        .push_en            (push_en),
        .pop_en             (pop_en),
        .matrix_mode_out    (matrix_mode_out),
        .matrix_load_en     (matrix_load_en),
        .matrix_load_id_en  (matrix_load_id_en),
        .matrix_mul_en      (matrix_mul_en),
        .matrix_mul_type    (matrix_mul_type),
        .matrix_addr        (matrix_addr),
        .perspective_div_en (perspective_div_en)
    );

endmodule

//--- source/gl_decode.sv
`timescale 1ns/1ps

`include "gl_settings.svh"

module gl_decode
    import gl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`GL_WORD_W-1:0] inst,
    input  logic                  inst_valid,
    input  logic [`GL_WORD_W-1:0] operand_data_0,
    input  logic [`GL_WORD_W-1:0] operand_data_1,
    input  logic [`GL_WORD_W-1:0] operand_data_2,
    input  logic [`GL_WORD_W-1:0] operand_data_3,
    output logic                  stall,
    output logic                  halted,
    output logic [`GL_ADDR_W-1:0] operand_addr,
    output logic                  issue,
    output gl_opcode_e            op,
    output logic [`GL_IMM_W-1:0]  literal,
    output logic [`GL_WORD_W-1:0] operand_0,
    output logic [`GL_WORD_W-1:0] operand_1,
    output logic [`GL_WORD_W-1:0] operand_2,
    output logic [`GL_WORD_W-1:0] operand_3
);

    logic                 inst_type;
    logic [`GL_IMM_W-1:0] imm;
    gl_opcode_e           inst_op;
    gl_decode_state_e     state;
    gl_decode_state_e     state_next;

    //////////////////////////////
    // Field split
    //////////////////////////////
    assign inst_type = inst[`GL_WORD_W-1];
    assign imm       = inst[`GL_WORD_W-2:`GL_OP_W];
    assign inst_op   = gl_opcode_e'(inst[`GL_OP_W-1:0]);

    // inst is held through the stall, so the address stays put
    // until the operand words come back
    assign operand_addr = imm[`GL_ADDR_W-1:0];

    assign op      = inst_op;
    assign literal = imm;

    // Type 0 commands carry the literal in operand word 0
    assign operand_0 = inst_type ? operand_data_0 :
                       {{(`GL_WORD_W-`GL_IMM_W){1'b0}}, imm};
    assign operand_1 = inst_type ? operand_data_1 : '0;
    assign operand_2 = inst_type ? operand_data_2 : '0;
    assign operand_3 = inst_type ? operand_data_3 : '0;

    assign halted = (state == DS_HALTED);

    //////////////////////////////
    // Decode FSM
    //////////////////////////////
    always_comb
    begin
        state_next = state;
        stall      = 1'b0;
        issue      = 1'b0;
        case (state)
            DS_RUN:
            begin
                if (inst_valid)
                begin
                    if (inst_op == OP_HALT)
                    begin
                        stall      = 1'b1;
                        state_next = DS_HALTED;
                    end
                    else if (inst_type)
                    begin
                        // One cycle for the operand read
                        stall      = 1'b1;
                        state_next = DS_OPERAND;
                    end
                    else
                    begin
                        issue = 1'b1;
                    end
                end
            end
            DS_OPERAND:
            begin
                issue      = 1'b1;
                state_next = DS_RUN;
            end
            DS_HALTED:
            begin
                stall = 1'b1;
            end
            default:
            begin
                state_next = DS_RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            state <= DS_RUN;
        else
            state <= state_next;
    end

    // Halt is permanent and nothing issues after it
    a_halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted && !issue && stall);

endmodule

//--- source/gl_fetch.sv
`timescale 1ns/1ps

`include "gl_settings.svh"

module gl_fetch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall,
    input  logic [`GL_WORD_W-1:0] inst_data,
    output logic [`GL_ADDR_W-1:0] inst_addr,
    output logic [`GL_WORD_W-1:0] inst,
    output logic                  inst_valid
);

    // Next address to request
    logic [`GL_ADDR_W-1:0] pc;

    // Address whose word is on inst_data this cycle
    logic [`GL_ADDR_W-1:0] data_addr;
    logic                  data_valid;

    // Under stall the memory re-reads the word in flight,
    // so it is still on inst_data once the stall drops
    assign inst_addr = stall ? data_addr : pc;

    //////////////////////////////
    // Program counter
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pc         <= '0;
            data_addr  <= '0;
            data_valid <= 1'b0;
        end
        else if (!stall)
        begin
            pc         <= pc + 1'b1;
            data_addr  <= pc;
            data_valid <= 1'b1;
        end
    end

    //////////////////////////////
    // Instruction register
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            inst       <= '0;
            inst_valid <= 1'b0;
        end
        else if (!stall)
        begin
            inst       <= inst_data;
            inst_valid <= data_valid;
        end
    end

endmodule

//--- source/gl_pkg.sv
`include "gl_settings.svh"

package gl_pkg;

    //////////////////////////////
    // Command word layout
    //////////////////////////////
    // Bit 31 is the type bit
    //   set when the immediate is an operand address
    //   clear when the immediate is a literal
    // Bits 30 to 8 hold the immediate
    // Bits 7 to 0 hold the opcode

    // Any code not listed here acts as a NOP
    typedef enum logic [`GL_OP_W-1:0] {
        OP_NOP           = 8'h00,
        OP_VIEWPORT      = 8'h01,
        OP_COLOR         = 8'h02,
        OP_PUSH_COLOR    = 8'h03,
        OP_POP_COLOR     = 8'h04,
        OP_MATRIX_MODE   = 8'h05,
        OP_LOAD_MATRIX   = 8'h06,
        OP_LOAD_IDENTITY = 8'h07,
        OP_MULT_MATRIX   = 8'h08,
        OP_PERSP_DIV     = 8'h09,
        OP_HALT          = 8'h0a
    } gl_opcode_e;

    // Decode FSM states
    typedef enum logic [1:0] {
        DS_RUN     = 2'd0,
        DS_OPERAND = 2'd1,
        DS_HALTED  = 2'd2
    } gl_decode_state_e;

endpackage

//--- source/gl_settings.svh
`ifndef GL_SETTINGS_SVH
`define GL_SETTINGS_SVH

// Data word width of the command memory
`define GL_WORD_W 32

// Command memory address width in words
`define GL_ADDR_W 10

// Opcode field at the bottom of a command word
`define GL_OP_W 8

// Immediate field between the opcode and the type bit
`define GL_IMM_W 23

// Colour stack entries
`define GL_COLOR_STACK_DEPTH 4

`endif

//--- source/gl_state_unit.sv
`timescale 1ns/1ps

`include "gl_settings.svh"

module gl_state_unit
    import gl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  issue,
    input  gl_opcode_e            op,
    input  logic [`GL_IMM_W-1:0]  literal,
    input  logic [`GL_WORD_W-1:0] operand_0,
    input  logic [`GL_WORD_W-1:0] operand_1,
    input  logic [`GL_WORD_W-1:0] operand_2,
    input  logic [`GL_WORD_W-1:0] operand_3,
    input  logic [`GL_ADDR_W-1:0] operand_addr,
    output logic [`GL_WORD_W-1:0] viewport_min_x,
    output logic [`GL_WORD_W-1:0] viewport_min_y,
    output logic [`GL_WORD_W-1:0] viewport_max_x,
    output logic [`GL_WORD_W-1:0] viewport_max_y,
    output logic [`GL_WORD_W-1:0] color_out,
    output logic                  push_en,
    output logic                  pop_en,
    output logic                  matrix_mode_out,
    output logic                  matrix_load_en,
    output logic                  matrix_load_id_en,
    output logic                  matrix_mul_en,
    output logic                  matrix_mul_type,
    output logic [`GL_ADDR_W-1:0] matrix_addr,
    output logic                  perspective_div_en
);

    localparam int CNT_W = $clog2(`GL_COLOR_STACK_DEPTH + 1);
    localparam int IDX_W = $clog2(`GL_COLOR_STACK_DEPTH);
    localparam logic [CNT_W-1:0] STACK_FULL = CNT_W'(`GL_COLOR_STACK_DEPTH);

    logic [`GL_WORD_W-1:0] color_stack [`GL_COLOR_STACK_DEPTH];
    logic [CNT_W-1:0]      stack_count;
    logic [CNT_W-1:0]      stack_top;
    logic                  do_push;
    logic                  do_pop;

    assign stack_top = stack_count - 1'b1;

    // Full pushes and empty pops are dropped silently
    assign do_push = issue && (op == OP_PUSH_COLOR) && (stack_count != STACK_FULL);
    assign do_pop  = issue && (op == OP_POP_COLOR) && (stack_count != '0);

    //////////////////////////////
    // Rendering state and strobes
    //////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            viewport_min_x     <= '0;
            viewport_min_y     <= '0;
            viewport_max_x     <= '0;
            viewport_max_y     <= '0;
            color_out          <= '0;
            stack_count        <= '0;
            push_en            <= 1'b0;
            pop_en             <= 1'b0;
            matrix_mode_out    <= 1'b0;
            matrix_load_en     <= 1'b0;
            matrix_load_id_en  <= 1'b0;
            matrix_mul_en      <= 1'b0;
            matrix_mul_type    <= 1'b0;
            perspective_div_en <= 1'b0;
        end
        else
        begin
            // Strobes last one cycle
            push_en            <= do_push;
            pop_en             <= do_pop;
            matrix_load_en     <= issue && (op == OP_LOAD_MATRIX);
            matrix_load_id_en  <= issue && (op == OP_LOAD_IDENTITY);
            matrix_mul_en      <= issue && (op == OP_MULT_MATRIX);
            perspective_div_en <= issue && (op == OP_PERSP_DIV);

            if (do_push)
                stack_count <= stack_count + 1'b1;
            if (do_pop)
            begin
                stack_count <= stack_top;
                color_out   <= color_stack[stack_top[IDX_W-1:0]];
            end

            if (issue)
            begin
                case (op)
                    OP_VIEWPORT:
                    begin
                        viewport_min_x <= operand_0;
                        viewport_min_y <= operand_1;
                        viewport_max_x <= operand_2;
                        viewport_max_y <= operand_3;
                    end
                    OP_COLOR:       color_out       <= operand_0;
                    OP_MATRIX_MODE: matrix_mode_out <= literal[0];
                    OP_MULT_MATRIX: matrix_mul_type <= literal[0];
                    default:
                    begin
                    end
                endcase
            end
        end
    end

    // Stack entries and matrix address
    always_ff @(posedge clk)
    begin
        if (do_push)
            color_stack[stack_count[IDX_W-1:0]] <= color_out;
        if (issue && (op == OP_LOAD_MATRIX || op == OP_MULT_MATRIX))
            matrix_addr <= operand_addr;
    end

    a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0({push_en, pop_en, matrix_load_en, matrix_load_id_en,
                  matrix_mul_en, perspective_div_en}));

    a_stack_bound: assert property (@(posedge clk) disable iff (!rst_n)
        stack_count <= STACK_FULL);

endmodule

//--- vlog.f
+incdir+source
source/gl_pkg.sv
source/gl_fetch.sv
source/gl_decode.sv
source/gl_state_unit.sv
source/gl_command_core.sv
dv/gl_clock_gen.sv
dv/gl_command_core_tb.sv
